// File: source/mem_id_pkg.sv
package mem_id_pkg;

    localparam int unsigned ID_W    = 4;
    localparam int unsigned NUM_SRC = 3;

    typedef logic [1:0] src_idx_t;  // 0 data, 1 bypass, 2 fetch

    // source numbering, same as the arbiter input order
    localparam src_idx_t SRC_DATA   = 2'd0;
    localparam src_idx_t SRC_BYPASS = 2'd1;
    localparam src_idx_t SRC_FETCH  = 2'd2;

    // fixed transaction ID encodings
    localparam logic [ID_W-1:0] ID_FETCH       = 4'b0000;
    localparam logic [ID_W-1:0] ID_DATA        = 4'b1100;
    localparam logic [1:0]      ID_BYPASS_BASE = 2'b10;    // top two bits, 10xx

    // owner of a transaction ID, anything unknown belongs to data
    function automatic src_idx_t id_to_src(input logic [ID_W-1:0] id);
        if (id == ID_FETCH) begin
            return SRC_FETCH;
        end
        if (id == ID_DATA) begin
            return SRC_DATA;
        end
        if (id[ID_W-1 -: 2] == ID_BYPASS_BASE) begin
            return SRC_BYPASS;
        end
        return SRC_DATA;
    endfunction

endpackage

// File: source/mem_chan_pkg.sv
package mem_chan_pkg;

    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 32;
    localparam int unsigned STRB_W = DATA_W / 8;
    localparam int unsigned LEN_W  = 8;

    typedef struct packed {
        logic [mem_id_pkg::ID_W-1:0] id;
        logic [ADDR_W-1:0]           addr;
        logic [LEN_W-1:0]            len;   // beats minus one
    } ar_chan_t;

    typedef struct packed {
        logic [mem_id_pkg::ID_W-1:0] id;
        logic [ADDR_W-1:0]           addr;
        logic [LEN_W-1:0]            len;
    } aw_chan_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;    // one bit per byte lane
        logic              last;
    } w_chan_t;

    typedef struct packed {
        logic [mem_id_pkg::ID_W-1:0] id;
        logic [DATA_W-1:0]           data;
        logic                        last;
    } r_chan_t;

    typedef struct packed {
        logic [mem_id_pkg::ID_W-1:0] id;
        logic [1:0]                  resp;  // okay / exokay / slverr / decerr
    } b_chan_t;

endpackage

// File: source/stream_arbiter.sv
`timescale 1ns/1ps

module stream_arbiter #(
    parameter int unsigned NumInp = 2,
    parameter type         DATA_T = logic
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [NumInp-1:0]  inp_valid_i,
    input  DATA_T [NumInp-1:0] inp_data_i,
    output logic [NumInp-1:0]  inp_ready_o,
    output logic               oup_valid_o,
    output DATA_T              oup_data_o,
    input  logic               oup_ready_i
);

    localparam int unsigned IdxW = (NumInp > 1) ? $clog2(NumInp) : 1;

    logic [IdxW-1:0] rr_q;      // priority pointer
    logic [IdxW-1:0] gnt_q;     // grant held while an offer waits
    logic            lock_q;
    logic [IdxW-1:0] rr_gnt;
    logic            rr_hit;
    logic [IdxW-1:0] gnt;
    logic [IdxW-1:0] ptr_next;
    int unsigned     cand;

    // ------------------------------
    // round-robin search
    // ------------------------------
    always_comb begin
        rr_gnt = rr_q;
        rr_hit = 1'b0;
        cand   = 0;
        for (int unsigned i = 0; i < NumInp; i++) begin
            cand = (32'(rr_q) + i) % NumInp;    // wraps past the top input
            if (!rr_hit && inp_valid_i[cand]) begin
                rr_gnt = IdxW'(cand);
                rr_hit = 1'b1;
            end
        end
    end

    // a locked grant keeps the waiting payload on the output
    assign gnt         = lock_q ? gnt_q : rr_gnt;
    assign oup_valid_o = lock_q ? inp_valid_i[gnt_q] : rr_hit;
    assign oup_data_o  = inp_data_i[gnt];

    always_comb begin
        inp_ready_o      = '0;
        inp_ready_o[gnt] = oup_valid_o & oup_ready_i;   // only the winner sees ready
    end

    assign ptr_next = (gnt == IdxW'(NumInp - 1)) ? '0 : gnt + 1'b1;

    // ------------------------------
    // pointer and lock state
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_q   <= '0;
            gnt_q  <= '0;
            lock_q <= 1'b0;
        end else if (oup_valid_o && oup_ready_i) begin
            rr_q   <= ptr_next;     // one past the input just served
            lock_q <= 1'b0;
        end else if (oup_valid_o) begin
            gnt_q  <= gnt;
            lock_q <= 1'b1;
        end
    end

endmodule

// File: source/write_steer.sv
`timescale 1ns/1ps

module write_steer #(
    parameter int unsigned StrDepth = 4
) (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    input  logic                                            aw_fire_i,
    input  logic [mem_id_pkg::ID_W-1:0]                     aw_id_i,
    input  logic [mem_id_pkg::NUM_SRC-1:0]                  src_w_valid_i,
    input  mem_chan_pkg::w_chan_t [mem_id_pkg::NUM_SRC-1:0] src_w_data_i,
    output logic [mem_id_pkg::NUM_SRC-1:0]                  src_w_ready_o,
    output logic                                            mem_w_valid_o,
    output mem_chan_pkg::w_chan_t                           mem_w_data_o,
    input  logic                                            mem_w_ready_i,
    output logic                                            aw_space_o
);

    import mem_id_pkg::*;

    localparam int unsigned PtrW = (StrDepth > 1) ? $clog2(StrDepth) : 1;
    localparam int unsigned CntW = $clog2(StrDepth + 1);

    src_idx_t        idx_q [StrDepth];  // owner of each open write, oldest at rd_ptr
    logic [PtrW-1:0] wr_ptr_q;
    logic [PtrW-1:0] rd_ptr_q;
    logic [CntW-1:0] cnt_q;
    src_idx_t        aw_src;
    src_idx_t        head;
    logic            empty;
    logic            push;
    logic            pop;

    function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
        return (ptr == PtrW'(StrDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign aw_src = id_to_src(aw_id_i);
    assign push   = aw_fire_i;
    assign pop    = mem_w_valid_o & mem_w_ready_i & mem_w_data_o.last;  // burst done

    // ------------------------------
    // source queue
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (push) begin
            idx_q[wr_ptr_q] <= aw_src;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                cnt_q <= cnt_q + 1'b1;
            end else if (pop && !push) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign empty      = (cnt_q == '0);
    assign aw_space_o = (cnt_q != CntW'(StrDepth));
    assign head       = idx_q[rd_ptr_q];

    // ------------------------------
    // W multiplexer
    // ------------------------------
    assign mem_w_valid_o = !empty & src_w_valid_i[head];
    assign mem_w_data_o  = src_w_data_i[head];

    always_comb begin
        src_w_ready_o = '0;
        if (!empty) begin
            src_w_ready_o[head] = mem_w_ready_i;
        end
    end

endmodule

// File: source/resp_router.sv
`timescale 1ns/1ps

// R and B share this, the payload itself is broadcast by the caller
module resp_router (
    input  logic [mem_id_pkg::ID_W-1:0]    rsp_id_i,
    input  logic                           rsp_valid_i,
    output logic                           rsp_ready_o,
    output logic [mem_id_pkg::NUM_SRC-1:0] src_valid_o,
    input  logic [mem_id_pkg::NUM_SRC-1:0] src_ready_i
);

    import mem_id_pkg::*;

    src_idx_t sel;  // destination of the current response

    // fetch 0000, bypass 10xx, data 1100 and everything else
    assign sel = id_to_src(rsp_id_i);

    // ------------------------------
    // valid out, ready back
    // ------------------------------
    always_comb begin
        src_valid_o      = '0;
        src_valid_o[sel] = rsp_valid_i;     // exactly one destination
    end

    assign rsp_ready_o = src_ready_i[sel];

endmodule

// File: source/mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux #(
    parameter int unsigned StrDepth = 4
) (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    // data cache, source 0
    input  logic                   data_ar_valid_i,
    input  mem_chan_pkg::ar_chan_t data_ar_i,
    output logic                   data_ar_ready_o,
    input  logic                   data_aw_valid_i,
    input  mem_chan_pkg::aw_chan_t data_aw_i,
    output logic                   data_aw_ready_o,
    input  logic                   data_w_valid_i,
    input  mem_chan_pkg::w_chan_t  data_w_i,
    output logic                   data_w_ready_o,
    output logic                   data_r_valid_o,
    output mem_chan_pkg::r_chan_t  data_r_o,
    input  logic                   data_r_ready_i,
    output logic                   data_b_valid_o,
    output mem_chan_pkg::b_chan_t  data_b_o,
    input  logic                   data_b_ready_i,
    // uncached bypass, source 1
    input  logic                   bypass_ar_valid_i,
    input  mem_chan_pkg::ar_chan_t bypass_ar_i,
    output logic                   bypass_ar_ready_o,
    input  logic                   bypass_aw_valid_i,
    input  mem_chan_pkg::aw_chan_t bypass_aw_i,
    output logic                   bypass_aw_ready_o,
    input  logic                   bypass_w_valid_i,
    input  mem_chan_pkg::w_chan_t  bypass_w_i,
    output logic                   bypass_w_ready_o,
    output logic                   bypass_r_valid_o,
    output mem_chan_pkg::r_chan_t  bypass_r_o,
    input  logic                   bypass_r_ready_i,
    output logic                   bypass_b_valid_o,
    output mem_chan_pkg::b_chan_t  bypass_b_o,
    input  logic                   bypass_b_ready_i,
    // instruction fetch, source 2
    input  logic                   fetch_ar_valid_i,
    input  mem_chan_pkg::ar_chan_t fetch_ar_i,
    output logic                   fetch_ar_ready_o,
    input  logic                   fetch_aw_valid_i,
    input  mem_chan_pkg::aw_chan_t fetch_aw_i,
    output logic                   fetch_aw_ready_o,
    input  logic                   fetch_w_valid_i,
    input  mem_chan_pkg::w_chan_t  fetch_w_i,
    output logic                   fetch_w_ready_o,
    output logic                   fetch_r_valid_o,
    output mem_chan_pkg::r_chan_t  fetch_r_o,
    input  logic                   fetch_r_ready_i,
    output logic                   fetch_b_valid_o,
    output mem_chan_pkg::b_chan_t  fetch_b_o,
    input  logic                   fetch_b_ready_i,
    // memory port
    output logic                   mem_ar_valid_o,
    output mem_chan_pkg::ar_chan_t mem_ar_o,
    input  logic                   mem_ar_ready_i,
    output logic                   mem_aw_valid_o,
    output mem_chan_pkg::aw_chan_t mem_aw_o,
    input  logic                   mem_aw_ready_i,
    output logic                   mem_w_valid_o,
    output mem_chan_pkg::w_chan_t  mem_w_o,
    input  logic                   mem_w_ready_i,
    input  logic                   mem_r_valid_i,
    input  mem_chan_pkg::r_chan_t  mem_r_i,
    output logic                   mem_r_ready_o,
    input  logic                   mem_b_valid_i,
    input  mem_chan_pkg::b_chan_t  mem_b_i,
    output logic                   mem_b_ready_o
);

    import mem_id_pkg::*;
    import mem_chan_pkg::*;

    logic aw_space;     // room for one more open write

    // ------------------------------
    // address arbitration
    // ------------------------------
    stream_arbiter #(
        .NumInp ( NUM_SRC   ),
        .DATA_T ( ar_chan_t )
    ) i_arb_ar (
        .clk_i       ( clk_i                                                  ),
        .rst_n_i     ( rst_n_i                                                ),
        .inp_valid_i ( {fetch_ar_valid_i, bypass_ar_valid_i, data_ar_valid_i} ),
        .inp_data_i  ( {fetch_ar_i, bypass_ar_i, data_ar_i}                   ),
        .inp_ready_o ( {fetch_ar_ready_o, bypass_ar_ready_o, data_ar_ready_o} ),
        .oup_valid_o ( mem_ar_valid_o                                         ),
        .oup_data_o  ( mem_ar_o                                               ),
        .oup_ready_i ( mem_ar_ready_i                                         )
    );

    // a full steering queue holds every AW back, memory never sees an uncounted one
    stream_arbiter #(
        .NumInp ( NUM_SRC   ),
        .DATA_T ( aw_chan_t )
    ) i_arb_aw (
        .clk_i       ( clk_i   ),
        .rst_n_i     ( rst_n_i ),
        .inp_valid_i ( {fetch_aw_valid_i, bypass_aw_valid_i, data_aw_valid_i}
                       & {NUM_SRC{aw_space}} ),
        .inp_data_i  ( {fetch_aw_i, bypass_aw_i, data_aw_i}                   ),
        .inp_ready_o ( {fetch_aw_ready_o, bypass_aw_ready_o, data_aw_ready_o} ),
        .oup_valid_o ( mem_aw_valid_o                                         ),
        .oup_data_o  ( mem_aw_o                                               ),
        .oup_ready_i ( mem_aw_ready_i & aw_space                              )
    );

    // ------------------------------
    // write data steering
    // ------------------------------
    write_steer #(
        .StrDepth ( StrDepth )
    ) i_steer_w (
        .clk_i         ( clk_i                                               ),
        .rst_n_i       ( rst_n_i                                             ),
        .aw_fire_i     ( mem_aw_valid_o & mem_aw_ready_i                     ),
        .aw_id_i       ( mem_aw_o.id                                         ),
        .src_w_valid_i ( {fetch_w_valid_i, bypass_w_valid_i, data_w_valid_i} ),
        .src_w_data_i  ( {fetch_w_i, bypass_w_i, data_w_i}                   ),
        .src_w_ready_o ( {fetch_w_ready_o, bypass_w_ready_o, data_w_ready_o} ),
        .mem_w_valid_o ( mem_w_valid_o                                       ),
        .mem_w_data_o  ( mem_w_o                                             ),
        .mem_w_ready_i ( mem_w_ready_i                                       ),
        .aw_space_o    ( aw_space                                            )
    );

    // ------------------------------
    // response routing
    // ------------------------------
    assign data_r_o   = mem_r_i;    // payload goes everywhere, valid goes to one
    assign bypass_r_o = mem_r_i;
    assign fetch_r_o  = mem_r_i;
    assign data_b_o   = mem_b_i;
    assign bypass_b_o = mem_b_i;
    assign fetch_b_o  = mem_b_i;

    resp_router i_route_r (
        .rsp_id_i    ( mem_r_i.id                                          ),
        .rsp_valid_i ( mem_r_valid_i                                       ),
        .rsp_ready_o ( mem_r_ready_o                                       ),
        .src_valid_o ( {fetch_r_valid_o, bypass_r_valid_o, data_r_valid_o} ),
        .src_ready_i ( {fetch_r_ready_i, bypass_r_ready_i, data_r_ready_i} )
    );

    resp_router i_route_b (
        .rsp_id_i    ( mem_b_i.id                                          ),
        .rsp_valid_i ( mem_b_valid_i                                       ),
        .rsp_ready_o ( mem_b_ready_o                                       ),
        .src_valid_o ( {fetch_b_valid_o, bypass_b_valid_o, data_b_valid_o} ),
        .src_ready_i ( {fetch_b_ready_i, bypass_b_ready_i, data_b_ready_i} )
    );

endmodule

// File: bench/tb_mem_port_mux.sv
`timescale 1ns/1ps

module tb_mem_port_mux;

    import mem_id_pkg::*;
    import mem_chan_pkg::*;

    localparam int unsigned DEPTH           = 4;
    localparam int unsigned NUM_TESTS       = 6;
    localparam int unsigned CYCLES_PER_TEST = 200;

    // data, bypass, fetch
    localparam logic [ID_W-1:0] SRC_IDS [3] = '{4'b1100, 4'b1001, 4'b0000};

    logic        clk;
    logic        rst_n;
    logic [2:0]  ar_valid;
    logic [2:0]  ar_ready;
    logic [2:0]  aw_valid;
    logic [2:0]  aw_ready;
    logic [2:0]  w_valid;
    logic [2:0]  w_ready;
    logic [2:0]  r_valid;
    logic [2:0]  r_ready;
    logic [2:0]  b_valid;
    logic [2:0]  b_ready;
    ar_chan_t    ar_pl [3];
    aw_chan_t    aw_pl [3];
    w_chan_t     w_pl [3];
    r_chan_t     r_pl [3];
    b_chan_t     b_pl [3];
    logic        mem_ar_valid;
    logic        mem_ar_ready;
    logic        mem_aw_valid;
    logic        mem_aw_ready;
    logic        mem_w_valid;
    logic        mem_w_ready;
    logic        mem_r_valid;
    logic        mem_r_ready;
    logic        mem_b_valid;
    logic        mem_b_ready;
    ar_chan_t    mem_ar;
    aw_chan_t    mem_aw;
    w_chan_t     mem_w;
    r_chan_t     mem_r;
    b_chan_t     mem_b;
    logic [31:0] lfsr;
    ar_chan_t    ar_q [$];  // accepted by the memory
    aw_chan_t    aw_q [$];
    w_chan_t     w_q [$];

    mem_port_mux #(
        .StrDepth ( DEPTH )
    ) dut_i (
        .clk_i(clk), .rst_n_i(rst_n),
        .data_ar_valid_i(ar_valid[0]), .data_ar_i(ar_pl[0]), .data_ar_ready_o(ar_ready[0]),
        .data_aw_valid_i(aw_valid[0]), .data_aw_i(aw_pl[0]), .data_aw_ready_o(aw_ready[0]),
        .data_w_valid_i(w_valid[0]), .data_w_i(w_pl[0]), .data_w_ready_o(w_ready[0]),
        .data_r_valid_o(r_valid[0]), .data_r_o(r_pl[0]), .data_r_ready_i(r_ready[0]),
        .data_b_valid_o(b_valid[0]), .data_b_o(b_pl[0]), .data_b_ready_i(b_ready[0]),
        .bypass_ar_valid_i(ar_valid[1]), .bypass_ar_i(ar_pl[1]), .bypass_ar_ready_o(ar_ready[1]),
        .bypass_aw_valid_i(aw_valid[1]), .bypass_aw_i(aw_pl[1]), .bypass_aw_ready_o(aw_ready[1]),
        .bypass_w_valid_i(w_valid[1]), .bypass_w_i(w_pl[1]), .bypass_w_ready_o(w_ready[1]),
        .bypass_r_valid_o(r_valid[1]), .bypass_r_o(r_pl[1]), .bypass_r_ready_i(r_ready[1]),
        .bypass_b_valid_o(b_valid[1]), .bypass_b_o(b_pl[1]), .bypass_b_ready_i(b_ready[1]),
        .fetch_ar_valid_i(ar_valid[2]), .fetch_ar_i(ar_pl[2]), .fetch_ar_ready_o(ar_ready[2]),
        .fetch_aw_valid_i(aw_valid[2]), .fetch_aw_i(aw_pl[2]), .fetch_aw_ready_o(aw_ready[2]),
        .fetch_w_valid_i(w_valid[2]), .fetch_w_i(w_pl[2]), .fetch_w_ready_o(w_ready[2]),
        .fetch_r_valid_o(r_valid[2]), .fetch_r_o(r_pl[2]), .fetch_r_ready_i(r_ready[2]),
        .fetch_b_valid_o(b_valid[2]), .fetch_b_o(b_pl[2]), .fetch_b_ready_i(b_ready[2]),
        .mem_ar_valid_o(mem_ar_valid), .mem_ar_o(mem_ar), .mem_ar_ready_i(mem_ar_ready),
        .mem_aw_valid_o(mem_aw_valid), .mem_aw_o(mem_aw), .mem_aw_ready_i(mem_aw_ready),
        .mem_w_valid_o(mem_w_valid), .mem_w_o(mem_w), .mem_w_ready_i(mem_w_ready),
        .mem_r_valid_i(mem_r_valid), .mem_r_i(mem_r), .mem_r_ready_o(mem_r_ready),
        .mem_b_valid_i(mem_b_valid), .mem_b_i(mem_b), .mem_b_ready_o(mem_b_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ------------------------------
    // memory responder and helpers
    // ------------------------------
    always @(negedge clk) begin     // sampled mid-cycle when inputs have settled
        if (rst_n && mem_ar_valid && mem_ar_ready) begin
            ar_q.push_back(mem_ar);
        end
        if (rst_n && mem_aw_valid && mem_aw_ready) begin
            aw_q.push_back(mem_aw);
        end
        if (rst_n && mem_w_valid && mem_w_ready) begin
            w_q.push_back(mem_w);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
    endfunction

    task automatic random_bit(output logic b);
        lfsr = lfsr_next(lfsr);
        b    = lfsr[0];
    endtask

    function automatic w_chan_t make_beat(input int s, input int b, input int len);
        w_chan_t w;
        w.data = 32'hD000_0000 | (32'(s) << 8) | 32'(b);
        w.strb = 4'hf;
        w.last = (b == len);
        return w;
    endfunction

    task automatic step();
        @(posedge clk);
        #10;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ar(input string name, input ar_chan_t exp, input ar_chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_aw(input string name, input aw_chan_t exp, input aw_chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_w(input string name, input w_chan_t exp, input w_chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_r(input string name, input r_chan_t exp, input r_chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_b(input string name, input b_chan_t exp, input b_chan_t act);
        if (act !== exp) begin
            abort_run($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic clear_inputs();
        for (int s = 0; s < 3; s++) begin
            ar_pl[s] = '0;
            aw_pl[s] = '0;
            w_pl[s]  = '0;
        end
        {ar_valid, aw_valid, w_valid, r_ready, b_ready} = '0;
        {mem_ar_ready, mem_aw_ready, mem_w_ready, mem_r_valid, mem_b_valid} = '0;
        mem_r = '0;
        mem_b = '0;
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------
    task automatic check_reset_state();
        repeat (2) @(negedge clk);
        check_bit("mem_ar_valid", 1'b0, mem_ar_valid);
        check_bit("mem_aw_valid", 1'b0, mem_aw_valid);
        check_bit("mem_w_valid", 1'b0, mem_w_valid);
        check_bit("r_valid", 1'b0, |r_valid);
        check_bit("b_valid", 1'b0, |b_valid);
        step();
    endtask

    task automatic round_robin_reads();
        ar_chan_t req;
        r_chan_t  exp_r;
        for (int s = 0; s < 3; s++) begin
            ar_pl[s] = '{id: SRC_IDS[s], addr: 32'h2000_0000 + 32'(s) * 32'h40, len: 8'd0};
        end
        ar_valid     = 3'b111;
        mem_ar_ready = 1'b1;
        for (int k = 0; k < 3; k++) begin   // pointer starts at data
            @(negedge clk);
            check_bit("mem_ar_valid", 1'b1, mem_ar_valid);
            check_ar("mem_ar", ar_pl[k], mem_ar);
            check_bit("ar_ready", 1'b1, ar_ready[k]);
            step();
            ar_valid[k] = 1'b0;
        end
        mem_ar_ready = 1'b0;
        r_ready      = 3'b111;
        for (int k = 0; k < 3; k++) begin
            req         = ar_q.pop_front();
            exp_r       = '{id: req.id, data: req.addr + 32'(req.id), last: 1'b1};
            mem_r       = exp_r;
            mem_r_valid = 1'b1;
            @(negedge clk);
            for (int j = 0; j < 3; j++) begin
                check_bit("r_valid", j == k, r_valid[j]);
            end
            check_r("r", exp_r, r_pl[k]);
            check_bit("mem_r_ready", 1'b1, mem_r_ready);
            step();
        end
        mem_r_valid = 1'b0;
        r_ready     = '0;
    endtask

    task automatic ar_backpressure();
        logic       rdy;
        logic       held;
        logic       joined;
        ar_chan_t   held_pl;
        logic [2:0] fired;
        ar_q.delete();
        ar_pl[1] = '{id: 4'b1011, addr: 32'h3000_0010, len: 8'd3};
        ar_pl[2] = '{id: 4'b0000, addr: 32'h3000_0020, len: 8'd7};
        ar_valid = 3'b100;  // bypass joins while fetch waits
        held     = 1'b0;
        joined   = 1'b0;
        while (ar_valid != '0) begin
            random_bit(rdy);
            mem_ar_ready = rdy;
            fired        = '0;
            @(negedge clk);
            if (held) begin
                check_ar("mem_ar held", held_pl, mem_ar);   // stalled offer must not move
            end
            held    = mem_ar_valid && !mem_ar_ready;
            held_pl = mem_ar;
            if (mem_ar_valid && mem_ar_ready) begin
                check_bit("ar_ready onehot", 1'b1, $onehot(ar_ready));
                for (int j = 0; j < 3; j++) begin
                    if (ar_ready[j]) begin
                        check_bit("ar_valid", 1'b1, ar_valid[j]);
                        check_ar("mem_ar", ar_pl[j], mem_ar);
                        fired[j] = 1'b1;
                    end
                end
            end
            step();
            ar_valid = ar_valid & ~fired;
            if (!joined) begin
                ar_valid[1] = 1'b1;     // ahead of fetch in pointer order
                joined      = 1'b1;
            end
        end
        mem_ar_ready = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("mem_ar_valid", 1'b0, mem_ar_valid);
        end
        if (ar_q.size() != 2) begin
            abort_run("AR requests were not each transferred exactly once");
        end
        step();
        mem_ar_ready = 1'b0;
    endtask

    task automatic write_steering();
        int         beat [3];
        int         lens [3];
        int         order [$];
        int         aw_cyc [$];
        int         cyc;
        int         n_w;
        int         s;
        logic [2:0] aw_fired;
        logic [2:0] w_fired;
        lens     = '{2, 1, 0};
        beat     = '{0, 0, 0};
        aw_pl[0] = '{id: 4'b1100, addr: 32'h4000_0000, len: 8'd2};
        aw_pl[1] = '{id: 4'b1001, addr: 32'h4000_1000, len: 8'd1};
        w_pl[0]  = make_beat(0, 0, lens[0]);
        w_pl[1]  = make_beat(1, 0, lens[1]);
        aw_valid     = 3'b011;
        w_valid      = 3'b011;     // beats offered before any AW
        mem_aw_ready = 1'b1;
        mem_w_ready  = 1'b1;
        cyc = 0;
        n_w = 0;
        while (n_w < 5) begin
            aw_fired = '0;
            w_fired  = '0;
            @(negedge clk);
            for (int j = 0; j < 3; j++) begin
                if (mem_aw_valid && aw_ready[j]) begin
                    check_aw("mem_aw", aw_pl[j], mem_aw);
                    order.push_back(j);
                    aw_cyc.push_back(cyc);
                    aw_fired[j] = 1'b1;
                end
            end
            if (mem_w_valid && mem_w_ready) begin
                if (order.size() == 0) begin
                    abort_run("W beat reached memory with no open write");
                end
                if (aw_cyc[0] == cyc) begin
                    abort_run("W beat transferred in the cycle of its own AW");
                end
                s = order[0];
                check_w("mem_w", make_beat(s, beat[s], lens[s]), mem_w);
                check_bit("w_ready", 1'b1, w_ready[s]);
                check_bit("w_ready other", 1'b0, |(w_ready & ~(3'b001 << s)));
                w_fired[s] = 1'b1;
                n_w++;
                if (beat[s] == lens[s]) begin
                    void'(order.pop_front());
                    void'(aw_cyc.pop_front());
                end
            end
            cyc++;
            step();
            aw_valid = aw_valid & ~aw_fired;
            for (int j = 0; j < 2; j++) begin
                if (w_fired[j] && beat[j] == lens[j]) begin
                    w_valid[j] = 1'b0;
                end else if (w_fired[j]) begin
                    beat[j]++;
                    w_pl[j] = make_beat(j, beat[j], lens[j]);
                end
            end
        end
        mem_aw_ready = 1'b0;
        mem_w_ready  = 1'b0;
    endtask

    task automatic queue_full_stall();
        aw_chan_t exp_aw;
        aw_q.delete();
        w_q.delete();
        aw_pl[0]     = '{id: 4'b1100, addr: 32'h5000_0000, len: 8'd0};
        w_pl[0]      = make_beat(0, 0, 0);
        mem_aw_ready = 1'b1;
        mem_w_ready  = 1'b1;
        aw_valid[0]  = 1'b1;
        for (int k = 0; k < DEPTH; k++) begin
            do @(negedge clk); while (!aw_ready[0]);
            step();
            aw_pl[0].addr = aw_pl[0].addr + 32'h40;
        end
        repeat (4) begin    // queue full and no beats sent
            @(negedge clk);
            check_bit("aw_ready", 1'b0, aw_ready[0]);
            check_bit("mem_aw_valid", 1'b0, mem_aw_valid);
        end
        step();
        w_valid[0] = 1'b1;
        @(negedge clk);
        check_bit("w_ready", 1'b1, w_ready[0]);
        check_bit("aw_ready", 1'b0, aw_ready[0]);
        step();
        w_valid[0] = 1'b0;
        @(negedge clk);
        check_bit("aw_ready", 1'b1, aw_ready[0]);
        check_aw("mem_aw", aw_pl[0], mem_aw);
        step();
        aw_valid[0] = 1'b0;
        w_valid[0]  = 1'b1;
        for (int k = 0; k < DEPTH; k++) begin   // drain the open writes
            do @(negedge clk); while (!w_ready[0]);
            step();
        end
        @(negedge clk);
        check_bit("w_ready", 1'b0, w_ready[0]);
        check_bit("mem_w_valid", 1'b0, mem_w_valid);
        step();
        if (aw_q.size() != DEPTH + 1 || w_q.size() != DEPTH + 1) begin
            abort_run("memory did not see each write address and beat exactly once");
        end
        for (int k = 0; k <= DEPTH; k++) begin
            exp_aw = '{id: 4'b1100, addr: 32'h5000_0000 + 32'(k) * 32'h40, len: 8'd0};
            check_aw("aw_q", exp_aw, aw_q[k]);
            check_w("w_q", make_beat(0, 0, 0), w_q[k]);
        end
        w_valid[0]   = 1'b0;
        mem_aw_ready = 1'b0;
        mem_w_ready  = 1'b0;
    endtask

    task automatic b_routing();
        logic [ID_W-1:0] ids [4];
        int              dest [4];
        b_chan_t         exp_b;
        ids  = '{4'b0000, 4'b1010, 4'b1100, 4'b0111};
        dest = '{2, 1, 0, 0};
        for (int k = 0; k < 4; k++) begin
            exp_b       = '{id: ids[k], resp: 2'(k)};
            mem_b       = exp_b;
            mem_b_valid = 1'b1;
            b_ready     = 3'b111 & ~(3'b001 << dest[k]);   // only the owner holds back
            @(negedge clk);
            check_bit("mem_b_ready", 1'b0, mem_b_ready);
            step();
            b_ready = 3'b111;
            @(negedge clk);
            for (int j = 0; j < 3; j++) begin
                check_bit("b_valid", j == dest[k], b_valid[j]);
            end
            check_b("b", exp_b, b_pl[dest[k]]);
            check_bit("mem_b_ready", 1'b1, mem_b_ready);
            step();
        end
        mem_b_valid = 1'b0;
        b_ready     = '0;
    endtask

    // ------------------------------
    // sequence and watchdog
    // ------------------------------
    initial begin
        lfsr  = 32'h6473;
        rst_n = 1'b0;
        clear_inputs();
        repeat (8) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_reset_state();
        round_robin_reads();
        ar_backpressure();
        write_steering();
        queue_full_stall();
        b_routing();
        $display("Regression passed");
        $finish;
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST + 8) @(posedge clk);
        abort_run("run timed out before all tests finished");
    end

endmodule

// File: verilog.f
source/mem_id_pkg.sv
source/mem_chan_pkg.sv
source/stream_arbiter.sv
source/write_steer.sv
source/resp_router.sv
source/mem_port_mux.sv
bench/tb_mem_port_mux.sv

// File: run.sh
#!/bin/sh
# build with Verilator and run, exit status is the simulation result
cd "$(dirname "$0")" \
    && verilator --binary --timing -Wno-fatal -j 0 \
        --top-module tb_mem_port_mux -f verilog.f \
    && ./obj_dir/Vtb_mem_port_mux \
    || exit 1
